// File: rtl/apb_share_pkg.sv
////////////////////
// shared types for the APB requester port
// holds bus widths, client request and response structs, the APB bus
// structs and the transfer FSM state encoding
////////////////////

`default_nettype none

package apb_share_pkg;

  ////////////////////
  // bus widths
  ////////////////////

  // byte address on the APB side
  typedef logic [31:0] addr_t;
  // one APB data word
  typedef logic [31:0] data_t;

  ////////////////////
  // client side
  ////////////////////

  // one register access from a client, this is also the payload of the arbiter
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  write;
  } client_req_t;

  // result handed back to the client that issued the access
  typedef struct packed {
    data_t rdata;
    logic  err;
  } client_rsp_t;

  ////////////////////
  // APB side
  ////////////////////

  // signals driven by the requester
  typedef struct packed {
    addr_t paddr;
    data_t pwdata;
    logic  pwrite;
    logic  psel;
    logic  penable;
  } apb_req_t;

  // signals driven by the completer
  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // transfer FSM states, RESP is the single cycle that returns the result
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2,
    RESP   = 2'd3
  } xfer_state_e;

endpackage

`default_nettype wire

// File: rtl/lzc.sv
////////////////////
// trailing-zero counter with an empty flag
// the fair arbiter uses it to find the next requester around its pointer
////////////////////

`timescale 1ns/1ps
`default_nettype none

module lzc #(
  parameter int unsigned WIDTH = 4,
  // width of the count, derived from WIDTH
  localparam int unsigned CntWidth = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0]    in_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                empty_o
);

  // the lowest set bit wins, so the scan runs from the top down and
  // every set bit found later overwrites the one before it
  // the count is zero when nothing is set, empty_o tells the two apart
  always_comb begin
    cnt_o = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (in_i[i]) begin
        cnt_o = CntWidth'(i);
      end
    end
  end

  // no bit set at all
  assign empty_o = ~|in_i;

endmodule

`default_nettype wire

// File: rtl/rr_arb_tree.sv
////////////////////
// logarithmic round-robin arbitration tree over client requests
// FairArb picks the jump-to-next-requester scheme, otherwise the pointer
// rotates by one; a decision is locked in while the grant is held back
////////////////////

`timescale 1ns/1ps
`default_nettype none

module rr_arb_tree #(
  parameter int unsigned NumIn   = 4,
  parameter bit          FairArb = 1'b1,
  // width of the index, derived from NumIn
  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [NumIn-1:0]                       req_i,
  output logic [NumIn-1:0]                       gnt_o,
  input  apb_share_pkg::client_req_t [NumIn-1:0] data_i,
  output logic                                   req_o,
  input  logic                                   gnt_i,
  output apb_share_pkg::client_req_t             data_o,
  output logic [IdxWidth-1:0]                    idx_o
);

  if (NumIn == 1) begin : gen_pass_through
    // a single client goes straight through
    assign req_o    = req_i[0];
    assign gnt_o[0] = gnt_i;
    assign data_o   = data_i[0];
    assign idx_o    = '0;
  end else begin : gen_arbiter
    localparam int unsigned NumLevels = $clog2(NumIn);
    localparam int unsigned NumNodes  = 2 ** NumLevels - 1;

    typedef logic [IdxWidth-1:0] idx_t;

    // node 0 is the root, the children of node n are 2n+1 and 2n+2
    idx_t                       [NumNodes-1:0] index_nodes;
    apb_share_pkg::client_req_t [NumNodes-1:0] data_nodes;
    logic                       [NumNodes-1:0] req_nodes;
    logic                       [NumNodes-1:0] gnt_nodes;

    // rr_q is the round-robin pointer, prio is the input that wins now
    idx_t             rr_q;
    idx_t             rr_d;
    idx_t             prio;
    logic             lock_q;
    logic [NumIn-1:0] req_q;
    logic [NumIn-1:0] req_d;

    assign req_o = req_nodes[0];
    assign data_o = data_nodes[0];
    assign idx_o = index_nodes[0];

    ////////////////////
    // lock-in
    ////////////////////

    // a request that is not granted freezes the request vector seen by the
    // tree, so the same input stays selected until the grant comes
    assign req_d = lock_q ? req_q : req_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        lock_q <= 1'b0;
        req_q  <= '0;
      end else begin
        lock_q <= req_o & ~gnt_i;
        req_q  <= req_d;
      end
    end

    ////////////////////
    // pointer update
    ////////////////////

    if (FairArb) begin : gen_fair
      logic [NumIn-1:0] upper_mask;
      logic [NumIn-1:0] lower_mask;
      idx_t             upper_idx;
      idx_t             lower_idx;
      logic             upper_empty;
      logic             lower_empty;

      // the pointer holds the last served input, requests above it come first
      for (genvar i = 0; i < NumIn; i++) begin : gen_mask
        assign upper_mask[i] = (idx_t'(i) > rr_q) ? req_d[i] : 1'b0;
        assign lower_mask[i] = (idx_t'(i) <= rr_q) ? req_d[i] : 1'b0;
      end

      lzc #(
        .WIDTH (NumIn)
      ) i_lzc_upper (
        .in_i    (upper_mask),
        .cnt_o   (upper_idx),
        .empty_o (upper_empty)
      );

      lzc #(
        .WIDTH (NumIn)
      ) i_lzc_lower (
        .in_i    (lower_mask),
        .cnt_o   (lower_idx),
        .empty_o (lower_empty)
      );

      // wrap to the lowest requester when nothing waits above the pointer
      assign prio = !upper_empty ? upper_idx : (!lower_empty ? lower_idx : rr_q);
      // remember who was served
      assign rr_d = (req_o && gnt_i) ? idx_o : rr_q;
    end else begin : gen_rotate
      // the pointer itself is the priority and moves on by one per grant
      assign prio = rr_q;
      assign rr_d = (req_o && gnt_i) ?
                    ((rr_q == idx_t'(NumIn - 1)) ? '0 : rr_q + idx_t'(1)) : rr_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else begin
        rr_q <= rr_d;
      end
    end

    ////////////////////
    // selector tree
    ////////////////////

    assign gnt_nodes[0] = gnt_i;

    // each level takes one pointer bit, the root uses the most significant
    for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
      for (genvar l = 0; l < 2 ** level; l++) begin : gen_level
        localparam int unsigned Node  = 2 ** level - 1 + l;
        localparam int unsigned Child = 2 ** (level + 1) - 1 + 2 * l;
        localparam int unsigned Bit   = NumLevels - 1 - level;

        if (level == NumLevels - 1) begin : gen_leaf
          if (2 * l < NumIn - 1) begin : gen_pair
            logic sel;

            // take the odd input if the even one is idle or the pointer says so
            assign sel = ~req_d[2*l] | (req_d[2*l+1] & prio[Bit]);
            assign req_nodes[Node] = req_d[2*l] | req_d[2*l+1];
            assign index_nodes[Node] = idx_t'(sel);
            assign data_nodes[Node] = sel ? data_i[2*l+1] : data_i[2*l];
            assign gnt_o[2*l] = gnt_nodes[Node] & req_d[2*l] & ~sel;
            assign gnt_o[2*l+1] = gnt_nodes[Node] & req_d[2*l+1] & sel;
          end else if (2 * l == NumIn - 1) begin : gen_single
            // odd input count leaves one input without a partner
            assign req_nodes[Node] = req_d[2*l];
            assign index_nodes[Node] = '0;
            assign data_nodes[Node] = data_i[2*l];
            assign gnt_o[2*l] = gnt_nodes[Node] & req_d[2*l];
          end else begin : gen_empty
            assign req_nodes[Node] = 1'b0;
            assign index_nodes[Node] = '0;
            assign data_nodes[Node] = '0;
          end
        end else begin : gen_inner
          logic sel;

          assign sel = ~req_nodes[Child] | (req_nodes[Child+1] & prio[Bit]);
          assign req_nodes[Node] = req_nodes[Child] | req_nodes[Child+1];
          // the right subtree sets this level's bit of the index
          assign index_nodes[Node] = sel ?
                                     (index_nodes[Child+1] | idx_t'(1 << Bit)) :
                                     index_nodes[Child];
          assign data_nodes[Node] = sel ? data_nodes[Child+1] : data_nodes[Child];
          assign gnt_nodes[Child] = gnt_nodes[Node] & ~sel;
          assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/apb_xfer_fsm.sv
////////////////////
// transfer FSM for the shared APB port
// accepts the arbitrated request in IDLE, runs SETUP and ACCESS on the bus
// and pulses the response to the issuing client in RESP
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_xfer_fsm #(
  parameter int unsigned NumClients = 4,
  // width of the client index, derived from NumClients
  localparam int unsigned IdxWidth = (NumClients > 1) ? $clog2(NumClients) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       arb_valid_i,
  input  apb_share_pkg::client_req_t arb_req_i,
  input  logic [IdxWidth-1:0]        arb_idx_i,
  output logic                       arb_ready_o,
  output apb_share_pkg::apb_req_t    apb_req_o,
  input  apb_share_pkg::apb_rsp_t    apb_rsp_i,
  output logic                       tmr_start_o,
  output logic                       tmr_run_o,
  input  logic                       tmr_expired_i,
  output logic [NumClients-1:0]      rsp_valid_o,
  output apb_share_pkg::client_rsp_t rsp_o
);

  apb_share_pkg::xfer_state_e state_q;
  apb_share_pkg::xfer_state_e state_d;
  apb_share_pkg::client_req_t req_q;
  apb_share_pkg::client_rsp_t rsp_q;
  logic [IdxWidth-1:0]        idx_q;
  logic                       accept;
  logic                       access_done;

  // only IDLE takes a new request
  assign arb_ready_o = (state_q == apb_share_pkg::IDLE);
  assign accept = arb_valid_i & arb_ready_o;

  // completer answers or the timer gives up, a real answer wins a tie
  assign access_done = (state_q == apb_share_pkg::ACCESS) &
                       (apb_rsp_i.pready | tmr_expired_i);

  ////////////////////
  // state sequence
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      apb_share_pkg::IDLE:   if (accept) state_d = apb_share_pkg::SETUP;
      apb_share_pkg::SETUP:  state_d = apb_share_pkg::ACCESS;
      apb_share_pkg::ACCESS: if (access_done) state_d = apb_share_pkg::RESP;
      apb_share_pkg::RESP:   state_d = apb_share_pkg::IDLE;
      default:               state_d = apb_share_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= apb_share_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // capture registers
  ////////////////////

  // request and client index are taken at acceptance, the result at the
  // end of ACCESS; a timed out access returns zero data with err set
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= arb_req_i;
      idx_q <= arb_idx_i;
    end
    if (access_done) begin
      if (apb_rsp_i.pready) begin
        rsp_q.rdata <= req_q.write ? '0 : apb_rsp_i.prdata;
        rsp_q.err   <= apb_rsp_i.pslverr;
      end else begin
        rsp_q.rdata <= '0;
        rsp_q.err   <= 1'b1;
      end
    end
  end

  // the timer is loaded in SETUP and counts through ACCESS
  assign tmr_start_o = (state_q == apb_share_pkg::SETUP);
  assign tmr_run_o = (state_q == apb_share_pkg::ACCESS);

  // address and data stay on the bus from SETUP through ACCESS
  always_comb begin
    apb_req_o.paddr   = req_q.addr;
    apb_req_o.pwdata  = req_q.wdata;
    apb_req_o.pwrite  = req_q.write;
    apb_req_o.psel    = (state_q == apb_share_pkg::SETUP) |
                        (state_q == apb_share_pkg::ACCESS);
    apb_req_o.penable = (state_q == apb_share_pkg::ACCESS);
  end

  // one pulse for the client that issued the access
  always_comb begin
    rsp_valid_o = '0;
    if (state_q == apb_share_pkg::RESP) begin
      rsp_valid_o[idx_q] = 1'b1;
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: rtl/apb_timeout_timer.sv
////////////////////
// timeout down-counter for the APB access phase
// flags an access phase that has run for TimeoutCycles cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_timeout_timer #(
  parameter int unsigned TimeoutCycles = 8,
  localparam int unsigned CntWidth = $clog2(TimeoutCycles + 1)
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic run_i,
  output logic expired_o
);

  logic [CntWidth-1:0] cnt_q;

  // the load happens on the edge into the first counted cycle, so the
  // count reaches zero in the last allowed cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CntWidth'(TimeoutCycles - 1);
    end else if (run_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - CntWidth'(1);
    end
  end

  // only meaningful while the phase is still running
  assign expired_o = run_i & (cnt_q == '0);

endmodule

`default_nettype wire

// File: rtl/apb_share_top.sv
////////////////////
// shared APB requester port
// clients issue one access each, the arbiter picks one, the FSM runs it
// on the APB master port and the timer ends accesses that never finish
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_share_top #(
  parameter int unsigned NumClients    = 4,
  parameter int unsigned TimeoutCycles = 8,
  parameter bit          FairArb       = 1'b1,
  localparam int unsigned IdxWidth = (NumClients > 1) ? $clog2(NumClients) : 1
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic [NumClients-1:0]                       req_valid_i,
  input  apb_share_pkg::client_req_t [NumClients-1:0] req_i,
  output logic [NumClients-1:0]                       req_ready_o,
  output logic [NumClients-1:0]                       rsp_valid_o,
  output apb_share_pkg::client_rsp_t                  rsp_o,
  output apb_share_pkg::apb_req_t                     apb_req_o,
  input  apb_share_pkg::apb_rsp_t                     apb_rsp_i
);

  // arbiter to FSM
  logic                       arb_valid;
  logic                       arb_ready;
  apb_share_pkg::client_req_t arb_req;
  logic [IdxWidth-1:0]        arb_idx;

  // FSM to timer
  logic tmr_start;
  logic tmr_run;
  logic tmr_expired;

  // the grant vector doubles as the ready of each client
  rr_arb_tree #(
    .NumIn   (NumClients),
    .FairArb (FairArb)
  ) i_rr_arb_tree (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_valid_i),
    .gnt_o  (req_ready_o),
    .data_i (req_i),
    .req_o  (arb_valid),
    .gnt_i  (arb_ready),
    .data_o (arb_req),
    .idx_o  (arb_idx)
  );

  apb_xfer_fsm #(
    .NumClients (NumClients)
  ) i_apb_xfer_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .arb_valid_i   (arb_valid),
    .arb_req_i     (arb_req),
    .arb_idx_i     (arb_idx),
    .arb_ready_o   (arb_ready),
    .apb_req_o     (apb_req_o),
    .apb_rsp_i     (apb_rsp_i),
    .tmr_start_o   (tmr_start),
    .tmr_run_o     (tmr_run),
    .tmr_expired_i (tmr_expired),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o)
  );

  apb_timeout_timer #(
    .TimeoutCycles (TimeoutCycles)
  ) i_apb_timeout_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (tmr_start),
    .run_i     (tmr_run),
    .expired_o (tmr_expired)
  );

endmodule

`default_nettype wire

// File: verification/apb_share_assertions.sv
////////////////////
// concurrent checks bound into the arbiter and the transfer FSM
// one-hot grants and pulses, a stable index under lock, APB phase rules
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_share_assertions #(
  parameter int unsigned NumIn    = 4,
  parameter int unsigned IdxWidth = 2
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic [NumIn-1:0]        onehot_i,
  input logic                    hold_i,
  input logic [IdxWidth-1:0]     idx_i,
  input apb_share_pkg::apb_req_t apb_req_i
);

  // grants in the arbiter and response pulses in the FSM
  onehot_vec: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(onehot_i))
    else $error("more than one bit set in a grant or response vector");

  // a pending choice that is held back keeps its index
  idx_locked: assert property (@(posedge clk_i) disable iff (!rst_ni) hold_i |=> $stable(idx_i))
    else $error("arbiter index moved while the grant was held back");

  penable_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_req_i.penable |-> apb_req_i.psel)
    else $error("penable high without psel");

  // the address is set in SETUP and must not move during ACCESS
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_req_i.penable |-> $stable(apb_req_i.paddr))
    else $error("paddr changed during the access phase");

endmodule

bind rr_arb_tree apb_share_assertions #(
  .NumIn    (NumIn),
  .IdxWidth (IdxWidth)
) i_arb_assertions (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .onehot_i  (gnt_o),
  .hold_i    (req_o & ~gnt_i),
  .idx_i     (idx_o),
  .apb_req_i ('0)
);

bind apb_xfer_fsm apb_share_assertions #(
  .NumIn    (NumClients),
  .IdxWidth (IdxWidth)
) i_fsm_assertions (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .onehot_i  (rsp_valid_o),
  .hold_i    (arb_valid_i & ~arb_ready_o),
  .idx_i     (arb_idx_i),
  .apb_req_i (apb_req_o)
);

`default_nettype wire

// File: verification/apb_share_tb.sv
////////////////////
// testbench for the shared APB requester port
// reads request vectors from the tests file, plays the APB completer and
// checks grant order, bus fields, latency and each client response
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_share_tb;

  localparam int unsigned NumClients    = 4;
  localparam int unsigned TimeoutCycles = 8;
  localparam bit          FairArb       = 1'b1;
  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned ResetCycles   = 16;
  localparam              TestFile      = "verification/apb_share_tests.txt";
  localparam int unsigned MemDepth      = 512;

  // a vector is a three word header and one record per requesting client
  localparam int unsigned HdrWords = 3;
  localparam int unsigned RecWords = 7;
  localparam int unsigned FAddr    = 0;
  localparam int unsigned FWrite   = 1;
  localparam int unsigned FWdata   = 2;
  localparam int unsigned FWait    = 3;
  localparam int unsigned FSlverr  = 4;
  localparam int unsigned FRdata   = 5;
  localparam int unsigned FErr     = 6;

  logic                                        clk_i;
  logic                                        rst_ni;
  logic [NumClients-1:0]                       req_valid_i;
  apb_share_pkg::client_req_t [NumClients-1:0] req_i;
  logic [NumClients-1:0]                       req_ready_o;
  logic [NumClients-1:0]                       rsp_valid_o;
  apb_share_pkg::client_rsp_t                  rsp_o;
  apb_share_pkg::apb_req_t                     apb_req_o;
  apb_share_pkg::apb_rsp_t                     apb_rsp_i;

  logic [31:0] tests_mem [0:MemDepth-1];
  // the vector under test holds one record row per client
  logic [31:0] rec [0:NumClients-1][0:RecWords-1];
  logic [NumClients-1:0] mask;
  logic [31:0] order;
  logic [31:0] rconst;

  int ptr = 0;
  int num_vectors = 0;
  int num_req = 0;
  int served = 0;
  int responded = 0;
  int cur = 0;
  int wait_cnt = 0;
  int latency = 0;
  bit busy = 1'b0;
  bit psel_prev = 1'b0;
  int checks = 0;
  int errors = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  apb_share_top #(
    .NumClients    (NumClients),
    .TimeoutCycles (TimeoutCycles),
    .FairArb       (FairArb)
  ) apb_share_top_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .apb_req_o   (apb_req_o),
    .apb_rsp_i   (apb_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // the watchdog limit is set once the vectors are counted
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("run stopped after %0d cycles because responses never arrived", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cond(bit ok, string what);
    checks++;
    assert (ok) else begin
      $display("at %0t %s", $time, what);
      errors++;
    end
  endtask

  // the order word lists clients left to right with the first grant leftmost
  function automatic int grant_at(int k);
    return (order >> (4 * (num_req - 1 - k))) & 32'hf;
  endfunction

  // edges from acceptance to the response pulse cover SETUP, ACCESS and RESP
  function automatic int expected_latency(logic [31:0] wait_states);
    if (wait_states < TimeoutCycles) begin
      return wait_states + 3;
    end
    return TimeoutCycles + 2;
  endfunction

  task automatic count_vectors();
    int p;
    p = 0;
    while (p < MemDepth - HdrWords && !$isunknown(tests_mem[p]) && tests_mem[p] != 0) begin
      num_vectors++;
      p += HdrWords + RecWords * $countones(tests_mem[p][NumClients-1:0]);
    end
  endtask

  task automatic load_vector();
    mask = tests_mem[ptr][NumClients-1:0];
    order = tests_mem[ptr+1];
    rconst = tests_mem[ptr+2];
    ptr += HdrWords;
    num_req = $countones(mask);
    for (int i = 0; i < NumClients; i++) begin
      for (int f = 0; f < RecWords; f++) begin
        rec[i][f] = mask[i] ? tests_mem[ptr+f] : 32'h0;
      end
      if (mask[i]) ptr += RecWords;
    end
  endtask

  // drives the completer answer for the next cycle with the address xor a constant as read data
  task automatic drive_completer(bit go);
    apb_share_pkg::apb_rsp_t rsp;
    rsp.pready = go;
    rsp.prdata = go ? (apb_req_o.paddr ^ rconst) : 32'h0;
    rsp.pslverr = go & rec[cur][FSlverr][0];
    apb_rsp_i <= rsp;
  endtask

  task automatic step_cycle();
    logic [NumClients-1:0]   next_bit;
    logic [NumClients-1:0]   cur_bit;
    apb_share_pkg::apb_req_t apb_now;
    @(posedge clk_i);
    // everything read here still holds the values of the cycle just ended
    apb_now = apb_req_o;
    next_bit = '0;
    // ready goes only to the client next in grant order and only while the port is idle
    if (!busy && served < num_req) next_bit[grant_at(served)] = 1'b1;
    if (busy) latency++;
    check_value("req_ready_o", 32'(next_bit), 32'(req_ready_o));
    // penable rises in the second cycle of psel
    check_value("apb_req_o.penable", 32'(apb_now.psel & psel_prev), 32'(apb_now.penable));
    psel_prev = apb_now.psel;
    if ((req_ready_o & req_valid_i) != '0) begin
      cur = grant_at(served);
      served++;
      busy = 1'b1;
      latency = 0;
      req_valid_i[cur] <= 1'b0;
    end
    if (apb_now.psel && !apb_now.penable) begin
      check_value("apb_req_o.paddr", rec[cur][FAddr], apb_now.paddr);
      check_value("apb_req_o.pwrite", rec[cur][FWrite], 32'(apb_now.pwrite));
      if (rec[cur][FWrite][0]) check_value("apb_req_o.pwdata", rec[cur][FWdata], apb_now.pwdata);
      wait_cnt = 0;
      drive_completer(rec[cur][FWait] == 0);
    end else if (apb_now.psel && apb_now.penable && !apb_rsp_i.pready) begin
      wait_cnt++;
      drive_completer(wait_cnt == rec[cur][FWait]);
    end else begin
      drive_completer(1'b0);
    end
    if (rsp_valid_o != '0) begin
      cur_bit = '0;
      cur_bit[cur] = 1'b1;
      check_cond(busy, "a response pulse came with no access outstanding");
      check_value("rsp_valid_o", 32'(cur_bit), 32'(rsp_valid_o));
      check_value("rsp_o.rdata", rec[cur][FRdata], rsp_o.rdata);
      check_value("rsp_o.err", rec[cur][FErr], 32'(rsp_o.err));
      check_value("apb_req_o.psel", 32'h0, 32'(apb_now.psel));
      check_value("response latency", expected_latency(rec[cur][FWait]), latency);
      busy = 1'b0;
      responded++;
    end
  endtask

  task automatic run_vector(int v);
    apb_share_pkg::client_req_t creq;
    load_vector();
    for (int i = 0; i < NumClients; i++) begin
      creq.addr = rec[i][FAddr];
      creq.wdata = rec[i][FWdata];
      creq.write = rec[i][FWrite][0];
      req_i[i] <= creq;
    end
    req_valid_i <= mask;
    served = 0;
    responded = 0;
    while (responded < num_req) step_cycle();
    $display("vector %0d mask %b: %0d responses, %0d errors so far", v, mask, responded, errors);
  endtask

  initial begin
    rst_ni <= 1'b0;
    req_valid_i <= '0;
    req_i <= '0;
    apb_rsp_i <= '0;
    $readmemh(TestFile, tests_mem);
    count_vectors();
    cycle_limit = ResetCycles + num_vectors * (TimeoutCycles + 8) * NumClients;
    check_cond(num_vectors > 0, "the tests file holds no vectors");
    repeat (ResetCycles) @(posedge clk_i);
    // bus and response pulses stay quiet in reset
    check_value("apb_req_o.psel", 32'h0, 32'(apb_req_o.psel));
    check_value("rsp_valid_o", 32'h0, 32'(rsp_valid_o));
    rst_ni <= 1'b1;
    for (int v = 0; v < num_vectors; v++) run_vector(v);
    $display("%0d vectors, %0d checks, %0d errors", num_vectors, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/apb_share_tests.txt
// header: client mask, grant order (first grant leftmost digit), read data xor constant
// per requesting client, lowest first: addr write wdata wait pslverr exp_rdata exp_err
1 0 0f0f0f0f // single write
00001000 1 cafe0001 0 0 00000000 0
4 2 0f0f0f0f // single read
00002004 0 00000000 0 0 0f0f2f0b 0
f 3012 12345678 // all clients at once
00000010 0 00000000 0 0 12345668 0
00000014 1 11110001 0 0 00000000 0
00000018 0 00000000 0 0 12345660 0
0000001c 1 33330003 0 0 00000000 0
3 01 a5a5a5a5 // wait states below the limit
00000100 0 00000000 3 0 a5a5a4a5 0
00000104 0 00000000 5 0 a5a5a4a1 0
8 3 a5a5a5a5 // completer never answers
00000200 0 00000000 ff 0 00000000 1
6 12 00ff00ff // pslverr on client 1 only
00000300 0 00000000 1 1 00ff03ff 1
00000304 1 22220002 0 0 00000000 0
a 31 0f0f0f0f // sparse mask
00000400 0 00000000 2 0 0f0f0b0f 0
00000408 1 44440004 0 0 00000000 0
a 31 0f0f0f0f // sparse mask again
00000410 1 11110010 0 0 00000000 0
0000040c 0 00000000 4 0 0f0f0b03 0
0 0 00000000 // end of vectors

// File: vlog.f
rtl/apb_share_pkg.sv
rtl/lzc.sv
rtl/rr_arb_tree.sv
rtl/apb_xfer_fsm.sv
rtl/apb_timeout_timer.sv
rtl/apb_share_top.sv
verification/apb_share_assertions.sv
verification/apb_share_tb.sv

// File: Bender.yml
package:
  name: apb_share

sources:
  - rtl/apb_share_pkg.sv
  - rtl/lzc.sv
  - rtl/rr_arb_tree.sv
  - rtl/apb_xfer_fsm.sv
  - rtl/apb_timeout_timer.sv
  - rtl/apb_share_top.sv
  - target: test
    files:
      - verification/apb_share_assertions.sv
      - verification/apb_share_tb.sv
